// File: verilog/mips_exec_pkg.sv
`default_nettype none

package mips_exec_pkg;

  // Primary opcodes
  localparam logic [5:0] op_special = 6'h00;
  localparam logic [5:0] op_regimm  = 6'h01;
  localparam logic [5:0] op_beq     = 6'h04;
  localparam logic [5:0] op_bne     = 6'h05;
  localparam logic [5:0] op_blez    = 6'h06;
  localparam logic [5:0] op_bgtz    = 6'h07;
  localparam logic [5:0] op_addiu   = 6'h09;
  localparam logic [5:0] op_slti    = 6'h0a;
  localparam logic [5:0] op_sltiu   = 6'h0b;
  localparam logic [5:0] op_andi    = 6'h0c;
  localparam logic [5:0] op_ori     = 6'h0d;
  localparam logic [5:0] op_xori    = 6'h0e;
  localparam logic [5:0] op_lui     = 6'h0f;
  localparam logic [5:0] op_lb      = 6'h20;
  localparam logic [5:0] op_lh      = 6'h21;
  localparam logic [5:0] op_lwl     = 6'h22;
  localparam logic [5:0] op_lw      = 6'h23;
  localparam logic [5:0] op_lbu     = 6'h24;
  localparam logic [5:0] op_lhu     = 6'h25;
  localparam logic [5:0] op_lwr     = 6'h26;
  localparam logic [5:0] op_sb      = 6'h28;
  localparam logic [5:0] op_sh      = 6'h29;
  localparam logic [5:0] op_swl     = 6'h2a;
  localparam logic [5:0] op_sw      = 6'h2b;

  // SPECIAL function codes
  localparam logic [5:0] fn_sll   = 6'h00;
  localparam logic [5:0] fn_srl   = 6'h02;
  localparam logic [5:0] fn_sra   = 6'h03;
  localparam logic [5:0] fn_sllv  = 6'h04;
  localparam logic [5:0] fn_srlv  = 6'h06;
  localparam logic [5:0] fn_srav  = 6'h07;
  localparam logic [5:0] fn_mfhi  = 6'h10;
  localparam logic [5:0] fn_mthi  = 6'h11;
  localparam logic [5:0] fn_mflo  = 6'h12;
  localparam logic [5:0] fn_mtlo  = 6'h13;
  localparam logic [5:0] fn_mult  = 6'h18;
  localparam logic [5:0] fn_multu = 6'h19;
  localparam logic [5:0] fn_div   = 6'h1a;
  localparam logic [5:0] fn_divu  = 6'h1b;
  localparam logic [5:0] fn_addu  = 6'h21;
  localparam logic [5:0] fn_subu  = 6'h23;
  localparam logic [5:0] fn_and   = 6'h24;
  localparam logic [5:0] fn_or    = 6'h25;
  localparam logic [5:0] fn_xor   = 6'h26;
  localparam logic [5:0] fn_slt   = 6'h2a;
  localparam logic [5:0] fn_sltu  = 6'h2b;

  // REGIMM condition in the rt field
  localparam logic [4:0] rt_bltz   = 5'h00;
  localparam logic [4:0] rt_bgez   = 5'h01;
  localparam logic [4:0] rt_bltzal = 5'h10;
  localparam logic [4:0] rt_bgezal = 5'h11;

  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_fields_t;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] immediate;
  } i_fields_t;

  typedef union packed {
    r_fields_t r_fields;
    i_fields_t i_fields;
  } instr_word_u;

  typedef enum logic {
    unit_alu,
    unit_muldiv
  } exec_unit_e;

endpackage

`default_nettype wire

// File: verilog/exec_issue_if.sv
`timescale 1ns/1ps
`default_nettype none

interface exec_issue_if;

  mips_exec_pkg::instr_word_u instr;  // Held from acceptance to next acceptance
  logic [31:0]                rs_data;
  logic [31:0]                rt_data;
  logic                       start_alu;  // One-cycle pulse
  logic                       start_md;

  modport ctrl (
    output instr, rs_data, rt_data, start_alu, start_md
  );

  modport alu (
    input instr, rs_data, rt_data, start_alu
  );

  modport md (
    input instr, rs_data, rt_data, start_md
  );

endinterface

`default_nettype wire

// File: verilog/int_alu.sv
`timescale 1ns/1ps
`default_nettype none

module int_alu (
  input  logic        clk,
  input  logic        reset,
  exec_issue_if.alu   issue,
  output logic        alu_done,
  output logic [31:0] alu_result,
  output logic        alu_branch
);

  logic [31:0] rs;
  logic [31:0] rt;
  logic [31:0] imm_sext;
  logic [31:0] imm_zext;
  logic [4:0]  sa;
  logic        rs_neg;
  logic        rs_zero;
  logic [31:0] result_d;
  logic        branch_d;

  assign rs       = issue.rs_data;
  assign rt       = issue.rt_data;
  assign imm_sext = {{16{issue.instr.i_fields.immediate[15]}}, issue.instr.i_fields.immediate};
  assign imm_zext = {16'h0000, issue.instr.i_fields.immediate};
  assign rs_neg   = rs[31];
  assign rs_zero  = (rs == 32'h0);

  // Variable shifts have funct bit 2 set
  assign sa = issue.instr.r_fields.funct[2] ? rs[4:0] : issue.instr.r_fields.shamt;

  always_comb
  begin
    result_d = 32'h0;  // Unknown codes and branches retire zero
    branch_d = 1'b0;
    case (issue.instr.i_fields.opcode)
      mips_exec_pkg::op_special:
        case (issue.instr.r_fields.funct)
          mips_exec_pkg::fn_sll,
          mips_exec_pkg::fn_sllv: result_d = rt << sa;
          mips_exec_pkg::fn_srl,
          mips_exec_pkg::fn_srlv: result_d = rt >> sa;
          mips_exec_pkg::fn_sra,
          mips_exec_pkg::fn_srav: result_d = $signed(rt) >>> sa;
          mips_exec_pkg::fn_addu: result_d = rs + rt;
          mips_exec_pkg::fn_subu: result_d = rs - rt;
          mips_exec_pkg::fn_and:  result_d = rs & rt;
          mips_exec_pkg::fn_or:   result_d = rs | rt;
          mips_exec_pkg::fn_xor:  result_d = rs ^ rt;
          mips_exec_pkg::fn_slt:  result_d = {31'h0, $signed(rs) < $signed(rt)};
          mips_exec_pkg::fn_sltu: result_d = {31'h0, rs < rt};
          default: ;
        endcase
      mips_exec_pkg::op_regimm:
        case (issue.instr.i_fields.rt)  // Link forms branch the same way
          mips_exec_pkg::rt_bltz,
          mips_exec_pkg::rt_bltzal: branch_d = rs_neg;
          mips_exec_pkg::rt_bgez,
          mips_exec_pkg::rt_bgezal: branch_d = ~rs_neg;
          default: ;
        endcase
      mips_exec_pkg::op_beq:   branch_d = (rs == rt);
      mips_exec_pkg::op_bne:   branch_d = (rs != rt);
      mips_exec_pkg::op_blez:  branch_d = rs_neg | rs_zero;
      mips_exec_pkg::op_bgtz:  branch_d = ~rs_neg & ~rs_zero;
      mips_exec_pkg::op_addiu: result_d = rs + imm_sext;
      mips_exec_pkg::op_slti:  result_d = {31'h0, $signed(rs) < $signed(imm_sext)};
      mips_exec_pkg::op_sltiu: result_d = {31'h0, rs < imm_sext};
      mips_exec_pkg::op_andi:  result_d = rs & imm_zext;
      mips_exec_pkg::op_ori:   result_d = rs | imm_zext;
      mips_exec_pkg::op_xori:  result_d = rs ^ imm_zext;
      mips_exec_pkg::op_lui:   result_d = {issue.instr.i_fields.immediate, 16'h0000};
      mips_exec_pkg::op_lb,
      mips_exec_pkg::op_lh,
      mips_exec_pkg::op_lwl,
      mips_exec_pkg::op_lw,
      mips_exec_pkg::op_lbu,
      mips_exec_pkg::op_lhu,
      mips_exec_pkg::op_lwr,
      mips_exec_pkg::op_sb,
      mips_exec_pkg::op_sh,
      mips_exec_pkg::op_swl,
      mips_exec_pkg::op_sw:    result_d = rs + imm_sext;  // Effective address
      default: ;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      alu_done   <= 1'b0;
      alu_branch <= 1'b0;
    end
    else
    begin
      alu_done <= issue.start_alu;
      if (issue.start_alu)
      begin
        alu_branch <= branch_d;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (issue.start_alu)
    begin
      alu_result <= result_d;
    end
  end

endmodule

`default_nettype wire

// File: verilog/hilo_muldiv.sv
`timescale 1ns/1ps
`default_nettype none

module hilo_muldiv #(
  parameter int div_steps_per_cycle = 1
) (
  input  logic        clk,
  input  logic        reset,
  exec_issue_if.md    issue,
  output logic        md_done,
  output logic [31:0] md_result,
  output logic [31:0] hi,
  output logic [31:0] lo
);

  localparam int div_cycles = 32 / div_steps_per_cycle;

  logic [5:0]         funct;
  logic               is_div;
  logic               rs_neg;
  logic               rt_neg;
  logic [31:0]        rs_mag;
  logic [31:0]        rt_mag;
  logic signed [63:0] prod_s;
  logic [63:0]        prod_u;
  logic               div_busy;
  logic [5:0]         div_count;
  logic [31:0]        rem_q;
  logic [31:0]        quot_q;
  logic [31:0]        rem_t;
  logic [31:0]        quot_t;
  logic [32:0]        partial;
  logic [32:0]        diff;

  assign funct  = issue.instr.r_fields.funct;
  assign is_div = (funct == mips_exec_pkg::fn_div) || (funct == mips_exec_pkg::fn_divu);
  assign rs_neg = (funct == mips_exec_pkg::fn_div) & issue.rs_data[31];
  assign rt_neg = (funct == mips_exec_pkg::fn_div) & issue.rt_data[31];
  assign rs_mag = rs_neg ? -issue.rs_data : issue.rs_data;
  assign rt_mag = rt_neg ? -issue.rt_data : issue.rt_data;
  assign prod_s = $signed(issue.rs_data) * $signed(issue.rt_data);
  assign prod_u = {32'h0, issue.rs_data} * {32'h0, issue.rt_data};

  // Restoring steps, div_steps_per_cycle per clock
  always_comb
  begin
    rem_t   = rem_q;
    quot_t  = quot_q;
    partial = 33'h0;
    diff    = 33'h0;
    for (int i = 0; i < div_steps_per_cycle; i++)
    begin
      partial = {rem_t, quot_t[31]};
      diff    = partial - {1'b0, rt_mag};
      rem_t   = diff[32] ? partial[31:0] : diff[31:0];  // Restore on borrow
      quot_t  = {quot_t[30:0], ~diff[32]};
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      hi        <= 32'h0;
      lo        <= 32'h0;
      md_done   <= 1'b0;
      div_busy  <= 1'b0;
      div_count <= 6'h0;
    end
    else
    begin
      md_done <= 1'b0;
      if (issue.start_md)
      begin
        md_done <= ~is_div;
        case (funct)
          mips_exec_pkg::fn_mult:  {hi, lo} <= prod_s;
          mips_exec_pkg::fn_multu: {hi, lo} <= prod_u;
          mips_exec_pkg::fn_mthi:  hi <= issue.rs_data;
          mips_exec_pkg::fn_mtlo:  lo <= issue.rs_data;
          mips_exec_pkg::fn_div,
          mips_exec_pkg::fn_divu:
          begin
            div_busy  <= 1'b1;
            div_count <= 6'(div_cycles);
          end
          default: ;
        endcase
      end
      else if (div_busy)
      begin
        div_count <= div_count - 6'd1;
        if (div_count == 6'd1)  // Last step, fix signs and write back
        begin
          div_busy <= 1'b0;
          md_done  <= 1'b1;
          if (issue.rt_data == 32'h0)
          begin
            lo <= 32'hffff_ffff;
            hi <= issue.rs_data;
          end
          else
          begin
            lo <= (rs_neg ^ rt_neg) ? -quot_t : quot_t;  // Truncate toward zero
            hi <= rs_neg ? -rem_t : rem_t;               // Sign of dividend
          end
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (issue.start_md)
    begin
      rem_q  <= 32'h0;
      quot_q <= rs_mag;
      if (funct == mips_exec_pkg::fn_mfhi)
      begin
        md_result <= hi;
      end
      else if (funct == mips_exec_pkg::fn_mflo)
      begin
        md_result <= lo;
      end
      else
      begin
        md_result <= 32'h0;
      end
    end
    else if (div_busy)
    begin
      rem_q  <= rem_t;
      quot_q <= quot_t;
    end
  end

endmodule

`default_nettype wire

// File: verilog/exec_retire.sv
`timescale 1ns/1ps
`default_nettype none

module exec_retire (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       cyc,
  input  logic                       stb,
  input  mips_exec_pkg::instr_word_u instr,
  input  logic [31:0]                rs_data,
  input  logic [31:0]                rt_data,
  input  logic                       alu_done,
  input  logic [31:0]                alu_result,
  input  logic                       alu_branch,
  input  logic                       md_done,
  input  logic [31:0]                md_result,
  exec_issue_if.ctrl                 issue,
  output logic                       ack,
  output logic [31:0]                result,
  output logic                       branch_taken
);

  logic                      busy;
  logic                      live;  // Master still holds cyc
  logic                      accept;
  logic                      is_md;
  logic                      unit_done;
  mips_exec_pkg::exec_unit_e unit_sel;
  mips_exec_pkg::exec_unit_e owner;

  // No new request in the ack cycle
  assign accept = cyc & stb & ~busy & ~ack;

  assign is_md = (instr.i_fields.opcode == mips_exec_pkg::op_special) &&
                 (instr.r_fields.funct inside {mips_exec_pkg::fn_mfhi, mips_exec_pkg::fn_mthi,
                                               mips_exec_pkg::fn_mflo, mips_exec_pkg::fn_mtlo,
                                               mips_exec_pkg::fn_mult, mips_exec_pkg::fn_multu,
                                               mips_exec_pkg::fn_div, mips_exec_pkg::fn_divu});

  assign unit_sel  = is_md ? mips_exec_pkg::unit_muldiv : mips_exec_pkg::unit_alu;
  assign unit_done = (owner == mips_exec_pkg::unit_muldiv) ? md_done : alu_done;

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      issue.instr   <= instr;
      issue.rs_data <= rs_data;
      issue.rt_data <= rt_data;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      busy            <= 1'b0;
      live            <= 1'b0;
      owner           <= mips_exec_pkg::unit_alu;
      issue.start_alu <= 1'b0;
      issue.start_md  <= 1'b0;
      ack             <= 1'b0;
      result          <= 32'h0;
      branch_taken    <= 1'b0;
    end
    else
    begin
      issue.start_alu <= accept && (unit_sel == mips_exec_pkg::unit_alu);
      issue.start_md  <= accept && (unit_sel == mips_exec_pkg::unit_muldiv);
      ack             <= 1'b0;
      if (accept)
      begin
        busy  <= 1'b1;
        live  <= 1'b1;
        owner <= unit_sel;
      end
      else if (busy)
      begin
        live <= live & cyc;
        if (unit_done)
        begin
          busy <= 1'b0;
          if (live && cyc)  // Orphaned requests finish silently
          begin
            ack <= 1'b1;
            if (owner == mips_exec_pkg::unit_muldiv)
            begin
              result       <= md_result;
              branch_taken <= 1'b0;
            end
            else
            begin
              result       <= alu_result;
              branch_taken <= alu_branch;
            end
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/mips_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module mips_exec_top #(
  parameter int div_steps_per_cycle = 1  // 1 or 2
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        cyc,
  input  logic        stb,
  input  logic [31:0] instr,
  input  logic [31:0] rs_data,
  input  logic [31:0] rt_data,
  output logic        ack,
  output logic [31:0] result,
  output logic        branch_taken,
  output logic [31:0] hi,
  output logic [31:0] lo
);

  logic        alu_done;
  logic [31:0] alu_result;
  logic        alu_branch;
  logic        md_done;
  logic [31:0] md_result;

  exec_issue_if issue_if ();

  exec_retire retire_i (
    .clk          (clk),
    .reset        (reset),
    .cyc          (cyc),
    .stb          (stb),
    .instr        (instr),
    .rs_data      (rs_data),
    .rt_data      (rt_data),
    .alu_done     (alu_done),
    .alu_result   (alu_result),
    .alu_branch   (alu_branch),
    .md_done      (md_done),
    .md_result    (md_result),
    .issue        (issue_if.ctrl),
    .ack          (ack),
    .result       (result),
    .branch_taken (branch_taken)
  );

  int_alu alu_i (
    .clk        (clk),
    .reset      (reset),
    .issue      (issue_if.alu),
    .alu_done   (alu_done),
    .alu_result (alu_result),
    .alu_branch (alu_branch)
  );

  hilo_muldiv #(
    .div_steps_per_cycle (div_steps_per_cycle)
  ) md_i (
    .clk       (clk),
    .reset     (reset),
    .issue     (issue_if.md),
    .md_done   (md_done),
    .md_result (md_result),
    .hi        (hi),
    .lo        (lo)
  );

endmodule

`default_nettype wire

// File: bench/tb_mips_exec.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_exec;

  localparam int clk_period   = 8;
  localparam int reset_cycles = 16;
  localparam int max_cases    = 256;
  localparam int alu_latency  = 2;   // Accepting edge to ack
  localparam int div_latency  = 34;  // 2 + 32 divide steps
  localparam int abort_after  = 4;   // Cycles before cyc is dropped
  localparam int settle       = 3;   // Long enough for a duplicate ack to show
  localparam int wd_per_case  = 60;

  // Columns of one case
  localparam int col_instr  = 0;
  localparam int col_rs     = 1;
  localparam int col_rt     = 2;
  localparam int col_result = 3;
  localparam int col_branch = 4;
  localparam int col_hi     = 5;
  localparam int col_lo     = 6;
  localparam int col_mask   = 7;

  logic        clk;
  logic        reset;
  logic        cyc;
  logic        stb;
  logic [31:0] instr;
  logic [31:0] rs_data;
  logic [31:0] rt_data;
  logic        ack;
  logic [31:0] result;
  logic        branch_taken;
  logic [31:0] hi;
  logic [31:0] lo;

  logic [31:0] cases [max_cases][8];
  int          num_cases = 0;
  int          ack_count = 0;
  bit          cases_loaded = 1'b0;

  mips_exec_top dut_i (
    .clk          (clk),
    .reset        (reset),
    .cyc          (cyc),
    .stb          (stb),
    .instr        (instr),
    .rs_data      (rs_data),
    .rt_data      (rt_data),
    .ack          (ack),
    .result       (result),
    .branch_taken (branch_taken),
    .hi           (hi),
    .lo           (lo)
  );

  initial
  begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  always @(posedge clk)
  begin
    if (ack === 1'b1)
      ack_count <= ack_count + 1;
  end

  task automatic compare_values(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("MISMATCH at %0t ns: %s expected %h actual %h", $time, name, expected, actual);
      $display("Errors found");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  // DIV and DIVU take the long path
  function automatic int expected_latency(input logic [31:0] word);
    if (word[31:26] == mips_exec_pkg::op_special &&
        (word[5:0] == mips_exec_pkg::fn_div || word[5:0] == mips_exec_pkg::fn_divu))
      return div_latency;
    return alu_latency;
  endfunction

  task automatic load_cases();
    int          fd;
    int          fields;
    string       line;
    logic [31:0] f [8];
    fd = $fopen("bench/exec_cases.txt", "r");
    if (fd == 0)
    begin
      $display("Cannot open bench/exec_cases.txt");
      $display("Errors found");
      $fatal(1, "No stimulus");
    end
    while ($fgets(line, fd) != 0)
    begin
      fields = $sscanf(line, "%h %h %h %h %h %h %h %h",
                       f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
      if (fields == 8 && num_cases < max_cases)  // Comment lines give no fields
      begin
        for (int i = 0; i < 8; i++)
          cases[num_cases][i] = f[i];
        num_cases = num_cases + 1;
      end
    end
    $fclose(fd);
  endtask

  task automatic run_case(input int idx);
    int          cycles;
    int          acks_before;
    logic [31:0] mask;
    mask        = cases[idx][col_mask];
    acks_before = ack_count;
    instr       = cases[idx][col_instr];
    rs_data     = cases[idx][col_rs];
    rt_data     = cases[idx][col_rt];
    cyc         = 1'b1;
    stb         = 1'b1;
    if (mask[4])
    begin
      repeat (abort_after) @(posedge clk);
      #1;
      cyc = 1'b0;  // Master walks away mid-divide
      stb = 1'b0;
      repeat (div_latency + settle - abort_after) @(posedge clk);
      #1;
      compare_values("ack count", acks_before, ack_count);
    end
    else
    begin
      cycles = 0;
      do
      begin
        @(posedge clk);
        #1;
        cycles++;
      end while (ack !== 1'b1);
      compare_values("ack latency", expected_latency(instr), cycles - 1);
      if (mask[0])
        compare_values("result", cases[idx][col_result], result);
      if (mask[1])
        compare_values("branch_taken", cases[idx][col_branch], {31'h0, branch_taken});
      @(posedge clk);  // stb stays high through the ack cycle
      #1;
      cyc = 1'b0;
      stb = 1'b0;
      repeat (settle) @(posedge clk);
      #1;
      compare_values("ack count", acks_before + 1, ack_count);
    end
    if (mask[2])
      compare_values("hi", cases[idx][col_hi], hi);
    if (mask[3])
      compare_values("lo", cases[idx][col_lo], lo);
  endtask

  initial
  begin
    wait (cases_loaded);
    repeat (num_cases * wd_per_case + reset_cycles) @(posedge clk);
    $display("Timeout: ack never arrived before the watchdog expired");
    $display("Errors found");
    $fatal(1, "Watchdog expired");
  end

  initial
  begin
    void'($urandom(11436));
    reset   = 1'b1;
    cyc     = 1'b0;
    stb     = 1'b0;
    instr   = 32'h0;
    rs_data = 32'h0;
    rt_data = 32'h0;
    load_cases();
    if (num_cases == 0)
    begin
      $display("No test cases found in bench/exec_cases.txt");
      $display("Errors found");
      $fatal(1, "No stimulus");
    end
    cases_loaded = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1;
    reset = 1'b0;
    @(posedge clk);
    #1;
    compare_values("ack", 32'h0, {31'h0, ack});
    compare_values("result", 32'h0, result);
    compare_values("branch_taken", 32'h0, {31'h0, branch_taken});
    compare_values("hi", 32'h0, hi);
    compare_values("lo", 32'h0, lo);
    for (int i = 0; i < num_cases; i++)
    begin
      run_case(i);
      repeat ($urandom % 4)  // Idle gap
      begin
        @(posedge clk);
        #1;
      end
    end
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/exec_cases.txt
# instr    rs       rt       result   branch   hi       lo       mask
# mask bits: 0 result, 1 branch_taken, 2 hi, 3 lo, 4 drop cyc mid-operation and expect no ack
00221821 7fffffff 00000001 80000000 00000000 00000000 00000000 0000000f
00221823 00000005 00000007 fffffffe 00000000 00000000 00000000 0000000f
00221824 f0f0ff00 0ff0f0f0 00f0f000 00000000 00000000 00000000 0000000f
00221825 f0000001 0000ff00 f000ff01 00000000 00000000 00000000 0000000f
00221826 aaaa5555 ffff0000 55555555 00000000 00000000 00000000 0000000f
2422fff0 00000100 00000000 000000f0 00000000 00000000 00000000 0000000f
3022ff0f 12345678 00000000 00005608 00000000 00000000 00000000 0000000f
34228000 00000001 00000000 00008001 00000000 00000000 00000000 0000000f
3822ffff 0000f0f0 00000000 00000f0f 00000000 00000000 00000000 0000000f
3c02beef 12345678 00000000 beef0000 00000000 00000000 00000000 0000000f
8c22fffc 10000000 00000000 0ffffffc 00000000 00000000 00000000 0000000f
00021900 00000000 80000001 00000010 00000000 00000000 00000000 0000000f
00021a02 00000000 f0001234 00f00012 00000000 00000000 00000000 0000000f
00021a03 00000000 f0001234 fff00012 00000000 00000000 00000000 0000000f
00221804 00000024 0000000f 000000f0 00000000 00000000 00000000 0000000f
00221806 ffffffe1 80000000 40000000 00000000 00000000 00000000 0000000f
00221807 0000003f 80000000 ffffffff 00000000 00000000 00000000 0000000f
0022182a fffffffe 00000001 00000001 00000000 00000000 00000000 0000000f
0022182b fffffffe 00000001 00000000 00000000 00000000 00000000 0000000f
2822ffff fffffffe 00000000 00000001 00000000 00000000 00000000 0000000f
2c22ffff fffffffe 00000000 00000001 00000000 00000000 00000000 0000000f
10220010 00001234 00001234 00000000 00000001 00000000 00000000 0000000f
14220010 00001234 00001234 00000000 00000000 00000000 00000000 0000000f
18200010 00000000 00000000 00000000 00000001 00000000 00000000 0000000f
18200010 00000007 00000000 00000000 00000000 00000000 00000000 0000000f
1c200010 00000005 00000000 00000000 00000001 00000000 00000000 0000000f
1c200010 80000000 00000000 00000000 00000000 00000000 00000000 0000000f
04200010 ffffffff 00000000 00000000 00000001 00000000 00000000 0000000f
04210010 00000000 00000000 00000000 00000001 00000000 00000000 0000000f
04300010 00000007 00000000 00000000 00000000 00000000 00000000 0000000f
04310010 80000000 00000000 00000000 00000000 00000000 00000000 0000000f
00220018 fffffffd 00000007 00000000 00000000 ffffffff ffffffeb 0000000f
00220019 ffffffff 00000002 00000000 00000000 00000001 fffffffe 0000000f
0022001a ffffffe9 00000005 00000000 00000000 fffffffd fffffffc 0000000f
0022001b 00000064 00000007 00000000 00000000 00000002 0000000e 0000000f
0022001a 00000011 fffffffb 00000000 00000000 00000002 fffffffd 0000000f
0022001a 00000009 00000000 00000000 00000000 00000009 ffffffff 0000000f
0022001b 80000000 00000000 00000000 00000000 80000000 ffffffff 0000000f
00200011 13572468 00000000 00000000 00000000 13572468 ffffffff 0000000f
00200013 9abcdef0 00000000 00000000 00000000 13572468 9abcdef0 0000000f
00221821 00000001 00000002 00000003 00000000 13572468 9abcdef0 0000000f
00001810 00000000 00000000 13572468 00000000 13572468 9abcdef0 0000000f
00001812 00000000 00000000 9abcdef0 00000000 13572468 9abcdef0 0000000f
fc000000 00000011 00000022 00000000 00000000 13572468 9abcdef0 0000000f
0022183f 00000011 00000022 00000000 00000000 13572468 9abcdef0 0000000f
0022001b 000003e8 00000003 00000000 00000000 00000001 0000014d 0000001c
00001812 00000000 00000000 0000014d 00000000 00000001 0000014d 0000000f

// File: list.f
verilog/mips_exec_pkg.sv
verilog/exec_issue_if.sv
verilog/int_alu.sv
verilog/hilo_muldiv.sv
verilog/exec_retire.sv
verilog/mips_exec_top.sv
bench/tb_mips_exec.sv

// File: Bender.yml
package:
  name: mips_exec

sources:
  - verilog/mips_exec_pkg.sv
  - verilog/exec_issue_if.sv
  - verilog/int_alu.sv
  - verilog/hilo_muldiv.sv
  - verilog/exec_retire.sv
  - verilog/mips_exec_top.sv
  - target: test
    files:
      - bench/tb_mips_exec.sv
